//--- rsa_pkg.sv
package rsa_pkg;

  // Datapath widths
  localparam int OPERAND_W   = 1024;
  localparam int ACC_W       = OPERAND_W + 2;
  localparam int BIT_CNT_W   = 11;

  // Host register map
  localparam int REG_W       = 32;
  localparam int EXP_W       = 32;
  localparam int EXP_LEN_W   = 6;

  // Byte distance between consecutive DMA blocks
  localparam int BLOCK_BYTES = 128;

  localparam logic [REG_W-1:0] CMD_IDLE    = 32'd0;
  localparam logic [REG_W-1:0] CMD_COMPUTE = 32'd1;

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [REG_W-1:0]     reg_word_t;
  typedef logic [EXP_W-1:0]     exponent_t;
  typedef logic [EXP_LEN_W-1:0] exp_len_t;

  // Order matches the DMA read block order
  typedef enum logic [1:0] {
    OP_X,
    OP_M,
    OP_R2
  } operand_sel_e;

  typedef struct packed {
    logic         valid;
    operand_sel_e sel;
    operand_t     data;
  } op_load_t;

  typedef struct packed {
    exponent_t exponent;
    exp_len_t  exp_len;
  } exp_cfg_t;

  // Low bits of status register 0
  typedef struct packed {
    logic dma_error;
    logic idle;
    logic done;
  } status_t;

  typedef enum logic [2:0] {
    H_IDLE,
    H_RX,
    H_RX_WAIT,
    H_COMPUTE,
    H_TX,
    H_TX_WAIT,
    H_DONE
  } host_state_e;

  typedef enum logic [2:0] {
    L_IDLE,
    L_SETUP_A,
    L_SETUP_XX,
    L_STEP1,
    L_STEP2,
    L_FINISH
  } ladder_state_e;

endpackage

//--- mont_mult.sv
`timescale 1ns/10ps

module mont_mult (
  input  logic               clk,
  input  logic               resetn,
  input  logic               start,
  input  rsa_pkg::operand_t  a,
  input  rsa_pkg::operand_t  b,
  input  rsa_pkg::operand_t  m,
  output rsa_pkg::operand_t  product,
  output logic               done
);
  import rsa_pkg::*;

  logic                 busy;
  logic [BIT_CNT_W-1:0] cnt;
  logic [ACC_W-1:0]     acc;
  logic [ACC_W-1:0]     sum_b;
  logic [ACC_W-1:0]     sum_m;
  logic [ACC_W-1:0]     acc_sub;
  logic                 last_step;

  // One bit of a per cycle, LSB first
  assign sum_b     = acc + (a[cnt[BIT_CNT_W-2:0]] ? ACC_W'(b) : '0);
  // Adding m clears the low bit so the halving is exact
  assign sum_m     = sum_b + (sum_b[0] ? ACC_W'(m) : '0);
  assign acc_sub   = acc - ACC_W'(m);
  assign last_step = (cnt == BIT_CNT_W'(OPERAND_W));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        if (last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // Accumulator stays below 2m, one subtraction brings it under m
  always_ff @(posedge clk) begin
    if (start) begin
      acc <= '0;
    end else if (busy && !last_step) begin
      acc <= sum_m >> 1;
    end
    if (busy && last_step) begin
      product <= (acc >= ACC_W'(m)) ? acc_sub[OPERAND_W-1:0] : acc[OPERAND_W-1:0];
    end
  end

  a_modulus_odd: assert property (@(posedge clk) disable iff (!resetn)
    start |-> m[0]);

endmodule

//--- mont_ladder.sv
`timescale 1ns/10ps

module mont_ladder (
  input  logic               clk,
  input  logic               resetn,
  input  rsa_pkg::op_load_t  op_load,
  input  logic               start,
  input  rsa_pkg::exp_cfg_t  exp_cfg,
  output rsa_pkg::operand_t  result,
  output logic               done
);
  import rsa_pkg::*;

  ladder_state_e state;
  operand_t      x_q;
  operand_t      m_q;
  operand_t      r2_q;
  operand_t      a_q;
  operand_t      xx_q;
  exponent_t     exp_q;
  exp_len_t      bit_idx;
  logic          cur_bit;
  logic          mult_start;
  logic          mult_done;
  operand_t      mult_a;
  operand_t      mult_b;
  operand_t      product;

  assign cur_bit = exp_q[bit_idx[EXP_LEN_W-2:0]];
  assign result  = a_q;

  // Operand routing per ladder step
  always_comb begin
    mult_a = a_q;
    mult_b = operand_t'(1);
    case (state)
      L_SETUP_A: mult_a = r2_q;
      L_SETUP_XX: begin
        mult_a = x_q;
        mult_b = r2_q;
      end
      L_STEP1: mult_b = xx_q;
      L_STEP2: begin
        mult_a = cur_bit ? xx_q : a_q;
        mult_b = cur_bit ? xx_q : a_q;
      end
      default: mult_b = operand_t'(1);
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state      <= L_IDLE;
      mult_start <= 1'b0;
      done       <= 1'b0;
    end else begin
      mult_start <= 1'b0;
      done       <= 1'b0;
      case (state)
        L_IDLE: begin
          if (start) begin
            state      <= L_SETUP_A;
            mult_start <= 1'b1;
          end
        end
        L_SETUP_A: begin
          if (mult_done) begin
            state      <= L_SETUP_XX;
            mult_start <= 1'b1;
          end
        end
        L_SETUP_XX, L_STEP1: begin
          if (mult_done) begin
            state      <= (state == L_STEP1) ? L_STEP2 : L_STEP1;
            mult_start <= 1'b1;
          end
        end
        L_STEP2: begin
          if (mult_done) begin
            state      <= (bit_idx == '0) ? L_FINISH : L_STEP1;
            mult_start <= 1'b1;
          end
        end
        L_FINISH: begin
          if (mult_done) begin
            state <= L_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (op_load.valid) begin
      case (op_load.sel)
        OP_X:    x_q  <= op_load.data;
        OP_M:    m_q  <= op_load.data;
        OP_R2:   r2_q <= op_load.data;
        default: x_q  <= x_q;
      endcase
    end
    if ((state == L_IDLE) && start) begin
      exp_q   <= exp_cfg.exponent;
      bit_idx <= exp_len_t'(exp_cfg.exp_len - 1'b1);
    end
    if (mult_done) begin
      case (state)
        L_SETUP_A, L_FINISH: a_q <= product;
        L_SETUP_XX: xx_q <= product;
        // Bit set updates A first, bit clear updates XX first
        L_STEP1: begin
          if (cur_bit) a_q <= product;
          else xx_q <= product;
        end
        L_STEP2: begin
          if (cur_bit) xx_q <= product;
          else a_q <= product;
          if (bit_idx != '0) bit_idx <= bit_idx - 1'b1;
        end
        default: a_q <= a_q;
      endcase
    end
  end

  mont_mult i_mult (
    .clk     (clk),
    .resetn  (resetn),
    .start   (mult_start),
    .a       (mult_a),
    .b       (mult_b),
    .m       (m_q),
    .product (product),
    .done    (mult_done)
  );

  a_exp_len_nonzero: assert property (@(posedge clk) disable iff (!resetn)
    start |-> (exp_cfg.exp_len != '0));

  a_load_when_idle: assert property (@(posedge clk) disable iff (!resetn)
    op_load.valid |-> (state == L_IDLE));

endmodule

//--- rsa_host_ctrl.sv
`timescale 1ns/10ps

module rsa_host_ctrl (
  input  logic                clk,
  input  logic                resetn,
  input  rsa_pkg::reg_word_t  cmd,
  input  rsa_pkg::reg_word_t  rx_base,
  input  rsa_pkg::reg_word_t  tx_addr,
  output rsa_pkg::reg_word_t  dma_rx_address,
  output rsa_pkg::reg_word_t  dma_tx_address,
  output logic                dma_rx_start,
  output logic                dma_tx_start,
  input  rsa_pkg::operand_t   dma_rx_data,
  input  logic                dma_done,
  input  logic                dma_idle,
  input  logic                dma_error,
  output rsa_pkg::op_load_t   op_load,
  output logic                ladder_start,
  input  logic                ladder_done,
  output rsa_pkg::status_t    status
);
  import rsa_pkg::*;

  host_state_e state;
  host_state_e next_state;
  logic [1:0]  blk_cnt;
  logic        last_blk;
  logic        cmd_compute;
  logic        cmd_idle;

  assign cmd_compute = (cmd == CMD_COMPUTE);
  assign cmd_idle    = (cmd == CMD_IDLE);
  assign last_blk    = (operand_sel_e'(blk_cnt) == OP_R2);

  // Block index selects the slot in the source buffer
  assign dma_rx_address = rx_base + reg_word_t'(blk_cnt) * reg_word_t'(BLOCK_BYTES);
  assign dma_tx_address = tx_addr;

  // Each completed read goes straight into the ladder
  assign op_load.valid = (state == H_RX_WAIT) && dma_done;
  assign op_load.sel   = operand_sel_e'(blk_cnt);
  assign op_load.data  = dma_rx_data;

  always_comb begin
    next_state = state;
    case (state)
      H_IDLE: begin
        if (cmd_compute) next_state = H_RX;
      end
      // Start only once the DMA reports idle
      H_RX: begin
        if (dma_idle) next_state = H_RX_WAIT;
      end
      H_RX_WAIT: begin
        if (dma_done) next_state = last_blk ? H_COMPUTE : H_RX;
      end
      H_COMPUTE: begin
        if (ladder_done) next_state = H_TX;
      end
      H_TX: begin
        if (dma_idle) next_state = H_TX_WAIT;
      end
      H_TX_WAIT: begin
        if (dma_done) next_state = H_DONE;
      end
      // Hold here while the command still reads compute
      // Otherwise the same command would restart the job
      H_DONE: begin
        if (cmd_idle) next_state = H_IDLE;
      end
      default: next_state = H_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state        <= H_IDLE;
      blk_cnt      <= '0;
      dma_rx_start <= 1'b0;
      dma_tx_start <= 1'b0;
      ladder_start <= 1'b0;
    end else begin
      state        <= next_state;
      dma_rx_start <= (state == H_RX) && dma_idle;
      dma_tx_start <= (state == H_TX) && dma_idle;
      // Ladder kicks off the cycle after R2 lands
      ladder_start <= (state == H_RX_WAIT) && dma_done && last_blk;
      if (state == H_IDLE) begin
        blk_cnt <= '0;
      end else if ((state == H_RX_WAIT) && dma_done) begin
        blk_cnt <= blk_cnt + 2'd1;
      end
    end
  end

  assign status.dma_error = dma_error;
  assign status.idle      = (state == H_IDLE);
  assign status.done      = (state == H_DONE);

  a_single_start: assert property (@(posedge clk) disable iff (!resetn)
    !(dma_rx_start && dma_tx_start));

  // DMA must not have left idle between the check and the pulse
  a_start_when_idle: assert property (@(posedge clk) disable iff (!resetn)
    (dma_rx_start || dma_tx_start) |-> dma_idle);

endmodule

//--- rsa_top.sv
`timescale 1ns/10ps

module rsa_top (
  input  logic                clk,
  input  logic                resetn,
  input  rsa_pkg::reg_word_t  reg_cmd,
  input  rsa_pkg::reg_word_t  reg_rx_base,
  input  rsa_pkg::reg_word_t  reg_tx_addr,
  input  rsa_pkg::reg_word_t  reg_exponent,
  input  rsa_pkg::exp_len_t   reg_exp_len,
  output rsa_pkg::reg_word_t  reg_status,
  input  rsa_pkg::operand_t   dma_rx_data,
  output rsa_pkg::operand_t   dma_tx_data,
  output rsa_pkg::reg_word_t  dma_rx_address,
  output rsa_pkg::reg_word_t  dma_tx_address,
  output logic                dma_rx_start,
  output logic                dma_tx_start,
  input  logic                dma_done,
  input  logic                dma_idle,
  input  logic                dma_error
);
  import rsa_pkg::*;

  op_load_t op_load;
  exp_cfg_t exp_cfg;
  status_t  status;
  logic     ladder_start;
  logic     ladder_done;

  assign exp_cfg.exponent = exponent_t'(reg_exponent);
  assign exp_cfg.exp_len  = reg_exp_len;

  // Status bits sit at the bottom of the register word
  assign reg_status = {{(REG_W - $bits(status_t)){1'b0}}, status};

  rsa_host_ctrl i_host_ctrl (
    .clk            (clk),
    .resetn         (resetn),
    .cmd            (reg_cmd),
    .rx_base        (reg_rx_base),
    .tx_addr        (reg_tx_addr),
    .dma_rx_address (dma_rx_address),
    .dma_tx_address (dma_tx_address),
    .dma_rx_start   (dma_rx_start),
    .dma_tx_start   (dma_tx_start),
    .dma_rx_data    (dma_rx_data),
    .dma_done       (dma_done),
    .dma_idle       (dma_idle),
    .dma_error      (dma_error),
    .op_load        (op_load),
    .ladder_start   (ladder_start),
    .ladder_done    (ladder_done),
    .status         (status)
  );

  mont_ladder i_ladder (
    .clk     (clk),
    .resetn  (resetn),
    .op_load (op_load),
    .start   (ladder_start),
    .exp_cfg (exp_cfg),
    .result  (dma_tx_data),
    .done    (ladder_done)
  );

endmodule

//--- tb_dma_model.sv
`timescale 1ns/10ps

module tb_dma_model #(
  parameter integer SEED  = 0,
  parameter int     DEPTH = 32
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic               rx_start,
  input  logic               tx_start,
  input  rsa_pkg::reg_word_t rx_address,
  input  rsa_pkg::reg_word_t tx_address,
  input  rsa_pkg::operand_t  tx_data,
  output rsa_pkg::operand_t  rx_data,
  output logic               done,
  output logic               idle,
  output logic               error,
  input  logic               error_req,
  input  logic               load_en,
  input  int                 load_idx,
  input  rsa_pkg::operand_t  load_data,
  output rsa_pkg::reg_word_t wr_addr,
  output rsa_pkg::operand_t  wr_data
);
  import rsa_pkg::*;

  operand_t  mem [DEPTH];
  integer    seed;
  int        delay;
  logic      is_rx;
  reg_word_t addr_q;

  initial seed = SEED;

  // One memory slot per block wrapping at the memory depth
  function automatic int block_index(input reg_word_t addr);
    return int'((addr / BLOCK_BYTES) % DEPTH);
  endfunction

  always @(posedge clk) begin
    if (!resetn) begin
      idle    <= 1'b1;
      done    <= 1'b0;
      error   <= 1'b0;
      rx_data <= '0;
      delay   <= 0;
      is_rx   <= 1'b0;
      addr_q  <= '0;
    end else begin
      done  <= 1'b0;
      error <= error_req;
      if (load_en) mem[load_idx % DEPTH] <= load_data;
      if (idle && (rx_start || tx_start)) begin
        idle   <= 1'b0;
        is_rx  <= rx_start;
        addr_q <= rx_start ? rx_address : tx_address;
        // Busy for 2 to 9 cycles
        delay  <= 2 + ($random(seed) & 7);
        if (tx_start) wr_data <= tx_data;
      end else if (!idle) begin
        if (delay == 0) begin
          done <= 1'b1;
          idle <= 1'b1;
          if (is_rx) begin
            rx_data <= mem[block_index(addr_q)];
          end else begin
            mem[block_index(addr_q)] <= wr_data;
            wr_addr <= addr_q;
          end
        end else begin
          delay <= delay - 1;
        end
      end
    end
  end

endmodule

//--- tb_rsa.sv
`timescale 1ns/10ps

module tb_rsa;
  import rsa_pkg::*;

  localparam int     TIMEOUT   = 200000;
  localparam int     DMA_DEPTH = 32;
  localparam integer RAND_SEED = 32'h45b0_2e7a;

  logic      clk;
  logic      resetn;
  reg_word_t reg_cmd;
  reg_word_t reg_rx_base;
  reg_word_t reg_tx_addr;
  reg_word_t reg_exponent;
  exp_len_t  reg_exp_len;
  reg_word_t reg_status;
  operand_t  dma_rx_data;
  operand_t  dma_tx_data;
  reg_word_t dma_rx_address;
  reg_word_t dma_tx_address;
  logic      dma_rx_start;
  logic      dma_tx_start;
  logic      dma_done;
  logic      dma_idle;
  logic      dma_error;
  logic      error_req;
  logic      load_en;
  int        load_idx;
  operand_t  load_data;
  reg_word_t wr_addr;
  operand_t  wr_data;
  integer    seed;
  int        rx_seen;
  int        tx_seen;

  rsa_top i_dut (
    .clk            (clk),
    .resetn         (resetn),
    .reg_cmd        (reg_cmd),
    .reg_rx_base    (reg_rx_base),
    .reg_tx_addr    (reg_tx_addr),
    .reg_exponent   (reg_exponent),
    .reg_exp_len    (reg_exp_len),
    .reg_status     (reg_status),
    .dma_rx_data    (dma_rx_data),
    .dma_tx_data    (dma_tx_data),
    .dma_rx_address (dma_rx_address),
    .dma_tx_address (dma_tx_address),
    .dma_rx_start   (dma_rx_start),
    .dma_tx_start   (dma_tx_start),
    .dma_done       (dma_done),
    .dma_idle       (dma_idle),
    .dma_error      (dma_error)
  );

  tb_dma_model #(.SEED(RAND_SEED), .DEPTH(DMA_DEPTH)) i_dma (
    .clk        (clk),
    .resetn     (resetn),
    .rx_start   (dma_rx_start),
    .tx_start   (dma_tx_start),
    .rx_address (dma_rx_address),
    .tx_address (dma_tx_address),
    .tx_data    (dma_tx_data),
    .rx_data    (dma_rx_data),
    .done       (dma_done),
    .idle       (dma_idle),
    .error      (dma_error),
    .error_req  (error_req),
    .load_en    (load_en),
    .load_idx   (load_idx),
    .load_data  (load_data),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic end_in_failure();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic value_mismatch(input string name, input operand_t got, input operand_t exp);
    $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end_in_failure();
  endtask

  task automatic report_error(input string text);
    $display("%s", text);
    end_in_failure();
  endtask

  task automatic wait_status(input int bit_pos, input logic value, input string what);
    int cycles;
    cycles = 0;
    while (reg_status[bit_pos] !== value) begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT) report_error({"Timed out waiting for status ", what});
    end
  endtask

  function automatic operand_t rand_operand();
    operand_t v;
    for (int i = 0; i < OPERAND_W / 32; i++) v[i*32 +: 32] = $random(seed);
    return v;
  endfunction

  // Top bit and bottom bit always set
  function automatic operand_t odd_modulus();
    operand_t m;
    m = rand_operand();
    m[OPERAND_W-1] = 1'b1;
    m[0] = 1'b1;
    return m;
  endfunction

  function automatic operand_t mul_mod(input operand_t a, input operand_t b, input operand_t m);
    logic [2*OPERAND_W-1:0] p;
    p = {{OPERAND_W{1'b0}}, a} * {{OPERAND_W{1'b0}}, b};
    return operand_t'(p % {{OPERAND_W{1'b0}}, m});
  endfunction

  // Square and multiply over the low len bits of e
  function automatic operand_t power_mod(input operand_t x, input exponent_t e, input int len,
                                         input operand_t m);
    operand_t r;
    r = operand_t'(1);
    for (int i = len - 1; i >= 0; i--) begin
      r = mul_mod(r, r, m);
      if (e[i]) r = mul_mod(r, x, m);
    end
    return r;
  endfunction

  // R is 2**1024 so R squared is 2**2048
  function automatic operand_t r_squared(input operand_t m);
    logic [2*OPERAND_W:0] r_sq;
    r_sq = '0;
    r_sq[2*OPERAND_W] = 1'b1;
    return operand_t'(r_sq % {{(OPERAND_W+1){1'b0}}, m});
  endfunction

  task automatic load_block(input int idx, input operand_t data);
    @(posedge clk);
    load_en   <= 1'b1;
    load_idx  <= idx;
    load_data <= data;
  endtask

  task automatic run_job(input int job, input operand_t x, input operand_t m,
                         input exponent_t e, input int len, input operand_t expected);
    load_block(job * 3, x);
    load_block(job * 3 + 1, m);
    load_block(job * 3 + 2, r_squared(m));
    @(posedge clk);
    load_en      <= 1'b0;
    reg_rx_base  <= reg_word_t'(job * 3 * BLOCK_BYTES);
    reg_tx_addr  <= reg_word_t'((16 + job) * BLOCK_BYTES);
    reg_exponent <= e;
    reg_exp_len  <= exp_len_t'(len);
    reg_cmd      <= CMD_COMPUTE;
    wait_status(0, 1'b1, "done");
    assert (wr_data == expected) else value_mismatch("dma_tx_data", wr_data, expected);
    assert (wr_addr == reg_tx_addr) else value_mismatch("dma_tx_address", wr_addr, reg_tx_addr);
    // Job must not restart while the command stays at compute
    repeat (40) @(posedge clk);
    assert (rx_seen == 3 && tx_seen == 1)
      else report_error("Job did not make exactly three DMA reads and one DMA write");
    reg_cmd <= CMD_IDLE;
    wait_status(1, 1'b1, "idle");
  endtask

  task automatic random_job(input int job, input int len);
    operand_t  m;
    operand_t  x;
    exponent_t e;
    m = odd_modulus();
    x = rand_operand() % m;
    e = $random(seed);
    if (len < EXP_W) e = e & ((exponent_t'(1) << len) - 1);
    run_job(job, x, m, e, len, power_mod(x, e, len, m));
  endtask

  // Transfer order and addresses counted per job
  always @(posedge clk) begin
    if (!resetn || reg_status[1]) begin
      rx_seen = 0;
      tx_seen = 0;
    end
    if (dma_rx_start) begin
      assert (rx_seen < 3) else report_error("More than three DMA reads in one job");
      assert (dma_rx_address == reg_rx_base + reg_word_t'(rx_seen * BLOCK_BYTES))
        else value_mismatch("dma_rx_address", dma_rx_address,
                            reg_rx_base + reg_word_t'(rx_seen * BLOCK_BYTES));
      rx_seen++;
    end
    if (dma_tx_start) begin
      assert (rx_seen == 3 && tx_seen == 0) else report_error("DMA write out of order");
      assert (dma_tx_address == reg_tx_addr)
        else value_mismatch("dma_tx_address", dma_tx_address, reg_tx_addr);
      tx_seen++;
    end
  end

  a_idle_no_start: assert property (@(posedge clk) disable iff (!resetn)
    (reg_cmd == CMD_IDLE) |-> !(dma_rx_start || dma_tx_start))
    else report_error("DMA start pulse while the command reads idle");

  a_done_holds: assert property (@(posedge clk) disable iff (!resetn)
    (reg_status[0] && reg_cmd == CMD_COMPUTE) |=> reg_status[0])
    else report_error("Status done dropped while the command still reads compute");

  a_done_no_start: assert property (@(posedge clk) disable iff (!resetn)
    reg_status[0] |-> !(dma_rx_start || dma_tx_start))
    else report_error("DMA start pulse while the status reads done");

  a_error_flag: assert property (@(posedge clk) disable iff (!resetn)
    reg_status[2] == dma_error)
    else value_mismatch("reg_status.dma_error", reg_status[2], dma_error);

  initial begin
    operand_t m;
    operand_t x;
    seed         = RAND_SEED;
    resetn       = 1'b0;
    reg_cmd      = CMD_IDLE;
    reg_rx_base  = '0;
    reg_tx_addr  = '0;
    reg_exponent = '0;
    reg_exp_len  = exp_len_t'(1);
    error_req    = 1'b0;
    load_en      = 1'b0;
    load_idx     = 0;
    load_data    = '0;
    repeat (10) @(posedge clk);
    resetn <= 1'b1;
    repeat (20) @(posedge clk);
    assert (reg_status == 32'h2) else value_mismatch("reg_status", reg_status, 32'h2);
    random_job(0, 8);
    random_job(1, 17);
    random_job(2, 32);
    // Exponent 0 gives 1 and exponent 1 gives X
    m = odd_modulus();
    x = rand_operand() % m;
    run_job(3, x, m, 32'd0, 1, operand_t'(1));
    run_job(4, x, m, 32'd1, 1, x);
    error_req <= 1'b1;
    wait_status(2, 1'b1, "dma_error set");
    error_req <= 1'b0;
    wait_status(2, 1'b0, "dma_error clear");
    repeat (10) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- sim.f
rsa_pkg.sv
mont_mult.sv
mont_ladder.sv
rsa_host_ctrl.sv
rsa_top.sv
tb_dma_model.sv
tb_rsa.sv
